//--- logic/channel_cfg.svh
`ifndef CHANNEL_CFG_SVH
`define CHANNEL_CFG_SVH

// Channel geometry
`define NUM_RANK    4
`define QUEUE_DEPTH 4

// Request field widths
`define ADDR_WIDTH 32
`define ID_WIDTH   4
`define USER_WIDTH 4

// Address map with two bit select fields
`define RANK_LSB  29
`define BG_LSB    27
`define BANK_LSB  25
// Column starts at address bit 0
`define COL_WIDTH 10

// Timing in controller clock cycles
`define T_CCD_S 2
`define T_CCD_L 4
`define T_RTW   6
`define T_WTR   8
`define T_RTR   3

`endif

//--- logic/channelPkg.sv
`include "channel_cfg.svh"

package channelPkg;

    // --------------------
    // Frontend request
    // --------------------
    typedef struct packed {
        logic [`ADDR_WIDTH-1:0] addr;
        logic [`ID_WIDTH-1:0]   id;
        logic [`USER_WIDTH-1:0] user;
        // High for a write, low for a read
        logic                   isWrite;
    } memReq_t;

    // Column command opcodes
    typedef enum logic [1:0] {
        CMD_DESELECT,
        CMD_READ,
        CMD_WRITE
    } cmdOp_e;

    // Popped queue head tagged with its rank
    typedef struct packed {
        logic [$clog2(`NUM_RANK)-1:0] rank;
        memReq_t                      req;
    } rankGrant_t;

    // --------------------
    // Command bus word
    // --------------------
    typedef struct packed {
        // Active low, one per rank
        logic [`NUM_RANK-1:0]  csN;
        cmdOp_e                op;
        logic [1:0]            bg;
        logic [1:0]            bank;
        logic [`COL_WIDTH-1:0] col;
    } ddrCmd_t;

endpackage

//--- logic/rankQueue.sv
`timescale 1ns/10ps
`include "channel_cfg.svh"

module rankQueue import channelPkg::*; #(
    parameter int RankIndex = 0
) (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          reqValid,
    input  memReq_t                       req,
    output logic                          ready,
    input  logic                          pop,
    output memReq_t                       head,
    output logic [$clog2(`QUEUE_DEPTH):0] count
);

    localparam int PtrWidth = $clog2(`QUEUE_DEPTH);
    // Rank field value this queue answers to
    localparam logic [1:0] RankSel = 2'(RankIndex);

    memReq_t             entries [`QUEUE_DEPTH];
    logic [PtrWidth-1:0] wrPtr;
    logic [PtrWidth-1:0] rdPtr;
    logic                push;

    // Circular pointer advance
    function automatic logic [PtrWidth-1:0] nextPtr(input logic [PtrWidth-1:0] ptr);
        if (ptr == PtrWidth'(`QUEUE_DEPTH - 1)) begin
            return '0;
        end else begin
            return ptr + 1'b1;
        end
    endfunction

    // Not full
    assign ready = (count != `QUEUE_DEPTH);

    // Take only requests decoded to this rank
    assign push = reqValid && ready && (req.addr[`RANK_LSB +: 2] == RankSel);

    // Oldest entry is valid whenever count is nonzero
    assign head = entries[rdPtr];

    // --------------------
    // Storage
    // --------------------
    always_ff @(posedge clk) begin
        if (push) begin
            entries[wrPtr] <= req;
        end
    end

    // Pointers and occupancy
    always_ff @(posedge clk) begin
        if (reset) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wrPtr <= nextPtr(wrPtr);
            end
            // Arbiter pops only nonempty queues
            if (pop) begin
                rdPtr <= nextPtr(rdPtr);
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

//--- logic/cmdGrantArbiter.sv
`timescale 1ns/10ps
`include "channel_cfg.svh"

module cmdGrantArbiter import channelPkg::*; (
    input  logic                          clk,
    input  logic                          reset,
    input  memReq_t                       headVector  [`NUM_RANK],
    input  logic [$clog2(`QUEUE_DEPTH):0] countVector [`NUM_RANK],
    output logic [`NUM_RANK-1:0]          popVector,
    output logic                          grantValid,
    output rankGrant_t                    grant,
    input  logic                          grantReady
);

    localparam int RankWidth = $clog2(`NUM_RANK);
    localparam int CountWidth = $clog2(`QUEUE_DEPTH) + 1;
    localparam int RtrWidth = $clog2(`T_RTR);
    // Grant register and issue register add two cycles of the gap
    localparam logic [RtrWidth-1:0] RtrHold = RtrWidth'(`T_RTR - 2);

    logic [RankWidth-1:0]  bestRank;
    logic [CountWidth-1:0] bestCount;
    logic [RankWidth-1:0]  lastRank;
    logic [RtrWidth-1:0]   rtrCount;
    logic                  loadEn;
    logic                  rtrBlock;
    logic                  doPop;

    // --------------------
    // Depth priority pick
    // --------------------
    // Strict compare keeps the lowest index on equal depth
    always_comb begin : depthPick
        bestRank = '0;
        bestCount = '0;
        for (int i = 0; i < `NUM_RANK; i++) begin
            if (countVector[i] > bestCount) begin
                bestRank = RankWidth'(i);
                bestCount = countVector[i];
            end
        end
    end : depthPick

    // Grant register free or handing off this cycle
    assign loadEn = !grantValid || grantReady;

    // Rank switch waits for the turnaround window
    assign rtrBlock = (bestRank != lastRank) && (rtrCount != '0);

    assign doPop = (bestCount != '0) && loadEn && !rtrBlock;

    // One hot pop to the chosen queue
    always_comb begin : popDecode
        for (int i = 0; i < `NUM_RANK; i++) begin
            popVector[i] = doPop && (bestRank == RankWidth'(i));
        end
    end : popDecode

    // --------------------
    // Grant register
    // --------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            grantValid <= 1'b0;
        end else if (loadEn) begin
            grantValid <= doPop;
        end
    end

    always_ff @(posedge clk) begin
        if (doPop) begin
            grant.rank <= bestRank;
            grant.req <= headVector[bestRank];
        end
    end

    // tRTR tracking
    // Counter reloads while any command of the last rank is still upstream of the bus
    always_ff @(posedge clk) begin
        if (reset) begin
            lastRank <= '0;
            rtrCount <= '0;
        end else begin
            if (doPop) begin
                lastRank <= bestRank;
            end
            if (doPop || grantValid || !grantReady) begin
                rtrCount <= RtrHold;
            end else if (rtrCount != '0) begin
                rtrCount <= rtrCount - 1'b1;
            end
        end
    end

endmodule

//--- logic/casIssueStage.sv
`timescale 1ns/10ps
`include "channel_cfg.svh"

module casIssueStage import channelPkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       grantValid,
    input  rankGrant_t grant,
    output logic       grantReady,
    input  logic       transReady,
    output ddrCmd_t    cmdBus,
    output logic       cmdIssued,
    output memReq_t    issuedReq
);

    localparam int GapWidth = $clog2(`T_WTR + 1);
    // Counter saturates at the longest gap
    localparam logic [GapWidth-1:0] GapMax = GapWidth'(`T_WTR);

    rankGrant_t          held;
    logic                heldValid;
    cmdOp_e              heldOp;
    logic [1:0]          heldBg;
    cmdOp_e              prevOp;
    logic [1:0]          prevBg;
    logic [GapWidth-1:0] sinceIssue;
    logic [GapWidth-1:0] needGap;
    logic                issueNow;
    ddrCmd_t             nextCmd;

    assign heldOp = held.req.isWrite ? CMD_WRITE : CMD_READ;
    assign heldBg = held.req.addr[`BG_LSB +: 2];

    // --------------------
    // Data bus spacing
    // --------------------
    always_comb begin : gapSelect
        if (prevOp == CMD_READ && heldOp == CMD_WRITE) begin
            needGap = GapWidth'(`T_RTW);
        end else if (prevOp == CMD_WRITE && heldOp == CMD_READ) begin
            needGap = GapWidth'(`T_WTR);
        end else if (heldBg == prevBg) begin
            needGap = GapWidth'(`T_CCD_L);
        end else begin
            needGap = GapWidth'(`T_CCD_S);
        end
    end : gapSelect

    assign issueNow = heldValid && transReady && (sinceIssue >= needGap);

    // Empty or draining this cycle
    assign grantReady = !heldValid || issueNow;

    // Issue register
    always_ff @(posedge clk) begin
        if (reset) begin
            heldValid <= 1'b0;
            sinceIssue <= GapMax;
            prevOp <= CMD_DESELECT;
            prevBg <= '0;
        end else begin
            if (grantReady) begin
                heldValid <= grantValid;
            end
            if (issueNow) begin
                sinceIssue <= GapWidth'(1);
                prevOp <= heldOp;
                prevBg <= heldBg;
            end else if (sinceIssue != GapMax) begin
                sinceIssue <= sinceIssue + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (grantValid && grantReady) begin
            held <= grant;
        end
    end

    // --------------------
    // Command bus drive
    // --------------------
    always_comb begin : cmdDecode
        nextCmd.csN = '1;
        nextCmd.op = CMD_DESELECT;
        nextCmd.bg = heldBg;
        nextCmd.bank = held.req.addr[`BANK_LSB +: 2];
        nextCmd.col = held.req.addr[`COL_WIDTH-1:0];
        if (issueNow) begin
            nextCmd.csN[held.rank] = 1'b0;
            nextCmd.op = heldOp;
        end
    end : cmdDecode

    always_ff @(posedge clk) begin
        if (reset) begin
            cmdBus <= '{csN: '1, op: CMD_DESELECT, default: '0};
            cmdIssued <= 1'b0;
        end else begin
            cmdBus <= nextCmd;
            cmdIssued <= issueNow;
        end
    end

    // Issued report toward the data buffer
    always_ff @(posedge clk) begin
        if (issueNow) begin
            issuedReq <= held.req;
        end
    end

endmodule

//--- logic/channelController.sv
`timescale 1ns/10ps
`include "channel_cfg.svh"

module channelController import channelPkg::*; (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 reqValid,
    input  memReq_t              req,
    output logic [`NUM_RANK-1:0] rankReady,
    input  logic                 transReady,
    output ddrCmd_t              cmdBus,
    output logic                 cmdIssued,
    output memReq_t              issuedReq
);

    // Queue to arbiter
    memReq_t                       headVector  [`NUM_RANK];
    logic [$clog2(`QUEUE_DEPTH):0] countVector [`NUM_RANK];
    logic [`NUM_RANK-1:0]          popVector;

    // Arbiter to issue stage
    logic       grantValid;
    logic       grantReady;
    rankGrant_t grant;

    // --------------------
    // Per rank queues
    // --------------------
    // Every queue sees the request and the rank field selects the taker
    for (genvar g = 0; g < `NUM_RANK; g++) begin : rankQueues
        rankQueue #(
            .RankIndex(g)
        ) queue (
            .clk(clk),
            .reset(reset),
            .reqValid(reqValid),
            .req(req),
            .ready(rankReady[g]),
            .pop(popVector[g]),
            .head(headVector[g]),
            .count(countVector[g])
        );
    end : rankQueues

    cmdGrantArbiter arbiter (
        .clk(clk),
        .reset(reset),
        .headVector(headVector),
        .countVector(countVector),
        .popVector(popVector),
        .grantValid(grantValid),
        .grant(grant),
        .grantReady(grantReady)
    );

    // Command bus and data bus timing
    casIssueStage issue (
        .clk(clk),
        .reset(reset),
        .grantValid(grantValid),
        .grant(grant),
        .grantReady(grantReady),
        .transReady(transReady),
        .cmdBus(cmdBus),
        .cmdIssued(cmdIssued),
        .issuedReq(issuedReq)
    );

endmodule

//--- sim/channelRef.svh
`ifndef CHANNEL_REF_SVH
`define CHANNEL_REF_SVH

// Rank field of a request address
function automatic int rankOf(input logic [`ADDR_WIDTH-1:0] addr);
    return int'(addr[`RANK_LSB +: 2]);
endfunction

// Smallest legal issue to issue distance on the data bus
function automatic int minGap(input logic prevWrite, input logic [1:0] prevBg,
                              input logic curWrite, input logic [1:0] curBg);
    if (!prevWrite && curWrite) begin
        return `T_RTW;
    end else if (prevWrite && !curWrite) begin
        return `T_WTR;
    end else if (prevBg == curBg) begin
        return `T_CCD_L;
    end else begin
        return `T_CCD_S;
    end
endfunction

// Command bus word expected for a request
function automatic ddrCmd_t expectCmd(input memReq_t r);
    ddrCmd_t cmd;
    cmd.csN = '1;
    cmd.csN[rankOf(r.addr)] = 1'b0;
    cmd.op = r.isWrite ? CMD_WRITE : CMD_READ;
    cmd.bg = r.addr[`BG_LSB +: 2];
    cmd.bank = r.addr[`BANK_LSB +: 2];
    cmd.col = r.addr[`COL_WIDTH-1:0];
    return cmd;
endfunction

// Deepest queue wins and the lowest rank takes a tie
// Returns -1 when every queue is empty
function automatic int pickRank(input int counts [`NUM_RANK]);
    int best;
    best = -1;
    for (int i = 0; i < `NUM_RANK; i++) begin
        if (counts[i] > 0 && (best < 0 || counts[i] > counts[best])) begin
            best = i;
        end
    end
    return best;
endfunction

`endif

//--- sim/channelControllerTb.sv
`timescale 1ns/10ps
`include "channel_cfg.svh"

module channelControllerTb import channelPkg::*; ();

    localparam int RandomCount = 200;
    // Random phase, back-pressure attempts and the priority burst
    localparam int TotalReqs = RandomCount + `QUEUE_DEPTH + 3 + 8;
    localparam int CycleLimit = 20 * TotalReqs + 200;

    logic                 clk = 1'b0;
    logic                 reset;
    logic                 reqValid;
    memReq_t              req;
    logic [`NUM_RANK-1:0] rankReady;
    logic                 transReady;
    ddrCmd_t              cmdBus;
    logic                 cmdIssued;
    memReq_t              issuedReq;

    int      seed = 68979;
    int      valueErrors = 0;
    int      otherErrors = 0;
    int      cycleCount = 0;
    int      edgeIndex = 0;
    int      issuedCount = 0;
    // One expected queue per rank
    memReq_t expQ [`NUM_RANK][$];
    // Expected rank order of the priority burst
    int      rankOrder [$];
    // Previous issue on the bus
    logic       haveLast = 1'b0;
    logic       lastWrite;
    logic [1:0] lastBg;
    int         lastRank;
    int         lastEdge;

    `include "channelRef.svh"

    channelController UUT (
        .clk(clk),
        .reset(reset),
        .reqValid(reqValid),
        .req(req),
        .rankReady(rankReady),
        .transReady(transReady),
        .cmdBus(cmdBus),
        .cmdIssued(cmdIssued),
        .issuedReq(issuedReq)
    );

    always #10 clk = ~clk;

    // --------------------
    // Helpers
    // --------------------
    task automatic checkField(input string name, input logic [31:0] expVal,
                              input logic [31:0] gotVal);
        assert (gotVal === expVal) else begin
            valueErrors++;
            $display("** Error at %0t: %s expected %h, got %h", $time, name, expVal, gotVal);
        end
    endtask

    // Negative rank keeps the random rank field
    function automatic memReq_t randomReq(input int rank);
        memReq_t r;
        r.addr = $random(seed);
        r.id = $random(seed);
        r.user = $random(seed);
        r.isWrite = $random(seed);
        if (rank >= 0) begin
            r.addr[`RANK_LSB +: 2] = rank[1:0];
        end
        return r;
    endfunction

    function automatic int pendingCount();
        int total;
        total = 0;
        for (int i = 0; i < `NUM_RANK; i++) begin
            total += expQ[i].size();
        end
        return total;
    endfunction

    // Holds the request until its rank takes it or maxWait cycles pass
    task automatic sendReq(input memReq_t r, input int maxWait, output logic taken);
        int waited;
        waited = 0;
        taken = 1'b0;
        reqValid = 1'b1;
        req = r;
        while (!taken && waited < maxWait) begin
            @(negedge clk);
            taken = rankReady[rankOf(r.addr)];
            @(posedge clk);
            #2;
            waited++;
        end
        reqValid = 1'b0;
    endtask

    task automatic sendChecked(input memReq_t r);
        logic taken;
        sendReq(r, 100, taken);
        assert (taken) else begin
            otherErrors++;
            $display("Request to rank %0d not accepted by time %0t", rankOf(r.addr), $time);
        end
    endtask

    task automatic waitDrain();
        while (pendingCount() != 0) begin
            @(posedge clk);
        end
        repeat (10) @(posedge clk);
        #2;
    endtask

    // --------------------
    // Scoreboard and compare
    // --------------------
    // Sampled on the falling edge where all DUT outputs are stable
    always @(negedge clk) begin : compare
        int      r;
        int      gap;
        int      need;
        memReq_t expReq;
        ddrCmd_t expBus;
        if (!reset) begin
            edgeIndex++;
            if (cmdIssued) begin
                issuedCount++;
                r = rankOf(issuedReq.addr);
                assert (expQ[r].size() != 0) else begin
                    otherErrors++;
                    $display("Command for rank %0d at time %0t with nothing pending", r, $time);
                end
                if (expQ[r].size() != 0) begin
                    expReq = expQ[r].pop_front();
                    expBus = expectCmd(expReq);
                    checkField("issuedReq.id", expReq.id, issuedReq.id);
                    checkField("issuedReq.user", expReq.user, issuedReq.user);
                    checkField("issuedReq.addr", expReq.addr, issuedReq.addr);
                    checkField("issuedReq.isWrite", expReq.isWrite, issuedReq.isWrite);
                    checkField("cmdBus.csN", expBus.csN, cmdBus.csN);
                    checkField("cmdBus.op", expBus.op, cmdBus.op);
                    checkField("cmdBus.bg", expBus.bg, cmdBus.bg);
                    checkField("cmdBus.bank", expBus.bank, cmdBus.bank);
                    checkField("cmdBus.col", expBus.col, cmdBus.col);
                    if (haveLast) begin
                        gap = edgeIndex - lastEdge;
                        need = minGap(lastWrite, lastBg, expReq.isWrite, expBus.bg);
                        // Rank switch also needs the turnaround
                        if (r != lastRank && need < `T_RTR) begin
                            need = `T_RTR;
                        end
                        assert (gap >= need) else begin
                            otherErrors++;
                            $display("Issue at %0t only %0d cycles after the last, %0d needed",
                                     $time, gap, need);
                        end
                    end
                    haveLast = 1'b1;
                    lastWrite = expReq.isWrite;
                    lastBg = expBus.bg;
                    lastRank = r;
                    lastEdge = edgeIndex;
                end
                if (rankOrder.size() != 0) begin
                    assert (r == rankOrder[0]) else begin
                        otherErrors++;
                        $display("Rank %0d issued at %0t, depth priority expects rank %0d",
                                 r, $time, rankOrder[0]);
                    end
                    void'(rankOrder.pop_front());
                end
            end
            // Taken at the coming rising edge
            if (reqValid && rankReady[rankOf(req.addr)]) begin
                expQ[rankOf(req.addr)].push_back(req);
            end
        end
    end : compare

    // Run limit
    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount >= CycleLimit) begin
            $display("Timeout, the run did not finish within %0d cycles", CycleLimit);
            $display("Error count: %0d wrong values, %0d other failures",
                     valueErrors, otherErrors + 1);
            $display("Simulation failed");
            $finish;
        end
    end

    // --------------------
    // Stimulus
    // --------------------
    initial begin : stimulus
        logic taken;
        int   accepted;
        int   issuedBefore;
        int   pick;
        int   counts [`NUM_RANK];
        reset = 1'b1;
        reqValid = 1'b0;
        req = '0;
        transReady = 1'b1;
        repeat (5) @(posedge clk);
        #2;
        reset = 1'b0;

        // Idle state after reset
        @(negedge clk);
        checkField("cmdBus.csN", {`NUM_RANK{1'b1}}, cmdBus.csN);
        checkField("cmdIssued", 1'b0, cmdIssued);
        checkField("rankReady", {`NUM_RANK{1'b1}}, rankReady);
        checkField("cmdBus.op", CMD_DESELECT, cmdBus.op);
        @(posedge clk);
        #2;

        // Random mixed traffic over all ranks
        repeat (RandomCount) begin
            sendChecked(randomReq(-1));
        end
        waitDrain();

        // Fill rank 2 against a stalled backend until it pushes back
        transReady = 1'b0;
        issuedBefore = issuedCount;
        accepted = 0;
        taken = 1'b1;
        while (taken && accepted < `QUEUE_DEPTH + 3) begin
            sendReq(randomReq(2), 8, taken);
            if (taken) begin
                accepted++;
            end
        end
        assert (accepted == `QUEUE_DEPTH + 2) else begin
            otherErrors++;
            $display("Rank 2 took %0d requests while stalled, %0d expected",
                     accepted, `QUEUE_DEPTH + 2);
        end
        @(negedge clk);
        checkField("rankReady[2]", 1'b0, rankReady[2]);
        assert (issuedCount == issuedBefore) else begin
            otherErrors++;
            $display("A command issued while transReady was low");
        end
        @(posedge clk);
        #2;
        transReady = 1'b1;
        waitDrain();

        // Rank 1 lands in the grant and issue registers before the deeper queues fill
        transReady = 1'b0;
        repeat (2) sendChecked(randomReq(1));
        repeat (4) sendChecked(randomReq(3));
        repeat (2) sendChecked(randomReq(0));
        for (int i = 0; i < `NUM_RANK; i++) begin
            counts[i] = 0;
        end
        counts[0] = 2;
        counts[3] = 4;
        rankOrder.push_back(1);
        rankOrder.push_back(1);
        for (int k = 0; k < 6; k++) begin
            pick = pickRank(counts);
            rankOrder.push_back(pick);
            counts[pick]--;
        end
        transReady = 1'b1;
        waitDrain();
        assert (rankOrder.size() == 0) else begin
            otherErrors++;
            $display("%0d commands of the priority burst never issued", rankOrder.size());
        end

        $display("Error count: %0d wrong values, %0d other failures", valueErrors, otherErrors);
        if (valueErrors == 0 && otherErrors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end : stimulus

endmodule

//--- vlog.f
+incdir+logic
+incdir+sim
logic/channelPkg.sv
logic/rankQueue.sv
logic/cmdGrantArbiter.sv
logic/casIssueStage.sv
logic/channelController.sv
sim/channelControllerTb.sv

//--- Bender.yml
package:
  name: channel_controller

sources:
  # Synthesizable controller
  - include_dirs:
      - logic
    files:
      - logic/channelPkg.sv
      - logic/rankQueue.sv
      - logic/cmdGrantArbiter.sv
      - logic/casIssueStage.sv
      - logic/channelController.sv

  # Testbench, top module channelControllerTb
  - target: simulation
    include_dirs:
      - logic
      - sim
    files:
      - sim/channelControllerTb.sv
